//--- src/tti_apb_pkg.sv
// APB bus types and register map of the TTI transmit path
`default_nettype none

package tti_apb_pkg;

  localparam int unsigned ApbAddrW = 12;
  localparam int unsigned ApbDataW = 32;

  // Request as driven by the APB master
  typedef struct packed {
    logic                psel;
    logic                penable;
    logic                pwrite;
    logic [ApbAddrW-1:0] paddr;
    logic [ApbDataW-1:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic                pready;
    logic [ApbDataW-1:0] prdata;
    logic                pslverr;
  } apb_rsp_t;

  // Register map
  localparam logic [ApbAddrW-1:0] TX_DESC_ADDR = 12'h000;
  localparam logic [ApbAddrW-1:0] TX_DATA_ADDR = 12'h004;
  localparam logic [ApbAddrW-1:0] STATUS_ADDR  = 12'h008;

endpackage

`default_nettype wire

//--- src/tti_tx_pkg.sv
// Descriptor, data word, queue and byte stream types of the TTI transmit path
`default_nettype none

package tti_tx_pkg;

  // Descriptor layout
  localparam int unsigned TxDescW  = 32;
  localparam int unsigned DataLenW = 16;

  typedef struct packed {
    logic [TxDescW-DataLenW-1:0] reserved;
    // Number of bytes to send
    logic [DataLenW-1:0]         data_len;
  } tx_desc_t;

  // Data words written by software
  localparam int unsigned TxDataW = 32;

  typedef logic [TxDataW-1:0] tx_word_t;

  // Queue sizes
  localparam int unsigned DescQueueDepth = 4;
  localparam int unsigned DataQueueDepth = 16;
  localparam int unsigned DepthW         = 16;

  // Byte stream towards the target FSM
  localparam int unsigned ByteW        = 8;
  localparam int unsigned BytesPerWord = TxDataW / ByteW;

  typedef struct packed {
    logic [ByteW-1:0] data;
    // Final byte of the descriptor
    logic             last;
  } tx_byte_t;

endpackage

`default_nettype wire

//--- src/tti_apb_regs.sv
// APB slave that pushes TX descriptors and data words and reports queue depths
`timescale 1ns/10ps
`default_nettype none

module tti_apb_regs (
  input  logic                            clk_i,
  input  logic                            rst_ni,

  input  tti_apb_pkg::apb_req_t           apb_req_i,
  output tti_apb_pkg::apb_rsp_t           apb_rsp_o,

  // Descriptor queue write side
  output logic                            desc_wvalid_o,
  output tti_tx_pkg::tx_desc_t            desc_wdata_o,
  input  logic                            desc_full_i,

  // Data queue write side
  output logic                            data_wvalid_o,
  output tti_tx_pkg::tx_word_t            data_wdata_o,
  input  logic                            data_full_i,

  input  logic [tti_tx_pkg::DepthW-1:0]   desc_depth_i,
  input  logic [tti_tx_pkg::DepthW-1:0]   data_depth_i
);

  import tti_apb_pkg::*;
  import tti_tx_pkg::*;

  logic                setup;
  logic                access;
  logic                sel_desc;
  logic                sel_data;
  logic                sel_status;
  logic                err_d;
  logic [ApbDataW-1:0] status;
  logic                push_desc_q;
  logic                push_data_q;
  logic                err_q;
  logic [ApbDataW-1:0] rdata_q;

  assign setup  = apb_req_i.psel & ~apb_req_i.penable;
  assign access = apb_req_i.psel & apb_req_i.penable;

  assign sel_desc   = apb_req_i.paddr == TX_DESC_ADDR;
  assign sel_data   = apb_req_i.paddr == TX_DATA_ADDR;
  assign sel_status = apb_req_i.paddr == STATUS_ADDR;

  // Descriptor depth in the upper half, data depth in the lower
  assign status = {desc_depth_i, data_depth_i};

  // Unmapped address or write into a full queue
  assign err_d = ~(sel_desc | sel_data | sel_status) |
                 (apb_req_i.pwrite & sel_desc & desc_full_i) |
                 (apb_req_i.pwrite & sel_data & data_full_i);

  // Decode in the setup phase, act in the access phase
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      push_desc_q <= 1'b0;
      push_data_q <= 1'b0;
      err_q       <= 1'b0;
    end else if (setup) begin
      push_desc_q <= apb_req_i.pwrite & sel_desc & ~desc_full_i;
      push_data_q <= apb_req_i.pwrite & sel_data & ~data_full_i;
      err_q       <= err_d;
    end else if (access) begin
      push_desc_q <= 1'b0;
      push_data_q <= 1'b0;
      err_q       <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (setup) begin
      rdata_q <= (sel_status & ~apb_req_i.pwrite) ? status : '0;
    end
  end

  // One push per access phase, payload straight from the bus
  assign desc_wvalid_o = access & push_desc_q;
  assign desc_wdata_o  = tx_desc_t'(apb_req_i.pwdata);
  assign data_wvalid_o = access & push_data_q;
  assign data_wdata_o  = tx_word_t'(apb_req_i.pwdata);

  assign apb_rsp_o = '{pready: 1'b1, prdata: rdata_q, pslverr: access & err_q};

endmodule

`default_nettype wire

//--- src/tti_queue.sv
// Synchronous FIFO for one payload type, reporting occupancy and empty
`timescale 1ns/10ps
`default_nettype none

module tti_queue #(
  parameter type         payload_t = logic [31:0],
  parameter int unsigned Depth     = 4
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,

  // Write side
  input  logic                          wvalid_i,
  input  payload_t                      wdata_i,
  output logic                          full_o,

  // Read side
  output logic                          rvalid_o,
  input  logic                          rready_i,
  output payload_t                      rdata_o,
  output logic [tti_tx_pkg::DepthW-1:0] depth_o,
  output logic                          empty_o
);

  import tti_tx_pkg::*;

  localparam int unsigned PtrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntW = $clog2(Depth + 1);

  payload_t        mem [Depth];
  logic [PtrW-1:0] wptr_q;
  logic [PtrW-1:0] rptr_q;
  logic [CntW-1:0] count_q;
  logic            push;
  logic            pop;

  assign full_o   = count_q == CntW'(Depth);
  assign empty_o  = count_q == '0;
  assign rvalid_o = ~empty_o;
  assign rdata_o  = mem[rptr_q];
  assign depth_o  = DepthW'(count_q);

  // Pushes into a full queue are dropped
  assign push = wvalid_i & ~full_o;
  assign pop  = rvalid_o & rready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      count_q <= '0;
    end else begin
      if (push) begin
        wptr_q <= (wptr_q == PtrW'(Depth - 1)) ? '0 : wptr_q + 1'b1;
      end
      if (pop) begin
        rptr_q <= (rptr_q == PtrW'(Depth - 1)) ? '0 : rptr_q + 1'b1;
      end
      // Simultaneous push and pop leave the count alone
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem[wptr_q] <= wdata_i;
    end
  end

endmodule

`default_nettype wire

//--- src/tx_word_to_byte.sv
// Word to byte converter, lowest byte first, with a flush of the held word
`timescale 1ns/10ps
`default_nettype none

module tx_word_to_byte (
  input  logic                         clk_i,
  input  logic                         rst_ni,

  // Data queue read side
  input  logic                         word_rvalid_i,
  output logic                         word_rready_o,
  input  tti_tx_pkg::tx_word_t         word_rdata_i,

  // Byte stream
  output logic                         byte_valid_o,
  input  logic                         byte_ready_i,
  output logic [tti_tx_pkg::ByteW-1:0] byte_o,

  input  logic                         flush_i
);

  import tti_tx_pkg::*;

  localparam int unsigned IdxW = $clog2(BytesPerWord);

  tx_word_t        word_q;
  logic [IdxW-1:0] idx_q;
  logic            held_q;
  logic            byte_hs;
  logic            last_byte;
  logic            pop;

  assign byte_hs   = held_q & byte_ready_i;
  assign last_byte = idx_q == IdxW'(BytesPerWord - 1);

  // Refill when empty or as the final byte leaves
  assign word_rready_o = ~flush_i & (~held_q | (byte_hs & last_byte));
  assign pop           = word_rvalid_i & word_rready_o;

  assign byte_valid_o = held_q;
  assign byte_o       = word_q[idx_q*ByteW +: ByteW];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      held_q <= 1'b0;
      idx_q  <= '0;
    end else if (flush_i) begin
      // Leftover bytes of the word are dropped
      held_q <= 1'b0;
      idx_q  <= '0;
    end else begin
      if (byte_hs) begin
        idx_q <= idx_q + 1'b1;
      end
      if (pop) begin
        held_q <= 1'b1;
      end else if (byte_hs && last_byte) begin
        held_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (pop) begin
      word_q <= word_rdata_i;
    end
  end

endmodule

`default_nettype wire

//--- src/descriptor_tx.sv
// TX descriptor handler that meters bytes to the target FSM and flushes on abort
`timescale 1ns/10ps
`default_nettype none

module descriptor_tx (
  input  logic                          clk_i,
  input  logic                          rst_ni,

  // Descriptor queue read side
  input  logic                          desc_rvalid_i,
  output logic                          desc_rready_o,
  input  tti_tx_pkg::tx_desc_t          desc_rdata_i,

  // Bytes from the converter
  input  logic                          byte_rvalid_i,
  output logic                          byte_rready_o,
  input  logic [tti_tx_pkg::ByteW-1:0]  byte_rdata_i,

  // Data queue status
  input  logic [tti_tx_pkg::DepthW-1:0] data_depth_i,
  input  logic                          data_empty_i,
  output logic                          tx_queue_flush_o,

  // Target FSM side
  input  logic                          tx_start_i,
  input  logic                          tx_abort_i,
  input  logic                          recovery_mode_enter_i,
  output logic                          tx_desc_avail_o,
  output tti_tx_pkg::tx_byte_t          tx_byte_o,
  output logic                          tx_byte_valid_o,
  input  logic                          tx_byte_ready_i,
  output logic                          tx_end_o
);

  import tti_tx_pkg::*;

  logic                desc_valid_q;
  logic [DataLenW-1:0] data_len_q;
  logic [DataLenW-1:0] count_q;
  logic                pending_q;
  logic                flush_q;
  logic                abort_req;
  logic [DepthW:0]     avail_words;
  logic [DepthW:0]     need_words;
  logic                start;
  logic                last_hs;
  logic                flush_start;
  logic                flush_done;
  logic                tx_end;

  assign abort_req = tx_abort_i | recovery_mode_enter_i;

  assign tx_desc_avail_o = desc_rvalid_i;
  assign desc_rready_o   = ~desc_valid_q & tx_start_i & desc_rvalid_i &
                           ~flush_q & ~abort_req;

  // Converter holds one more word than the queue reports
  assign avail_words = {1'b0, data_depth_i} + 1'b1;
  assign need_words  = (DepthW + 1)'(data_len_q / BytesPerWord);

  assign start = desc_valid_q & ~pending_q & ~flush_q & ~abort_req &
                 (avail_words >= need_words);

  // Byte path
  assign tx_byte_valid_o = pending_q & ~flush_q & byte_rvalid_i;
  assign tx_byte_o.data  = byte_rdata_i;
  assign tx_byte_o.last  = count_q == DataLenW'(1);
  assign last_hs         = tx_byte_valid_o & tx_byte_ready_i & tx_byte_o.last;

  // Discarded bytes are popped without a handshake during a flush
  assign byte_rready_o = (tx_byte_valid_o & tx_byte_ready_i) |
                         (flush_q & byte_rvalid_i);

  // Only a latched descriptor has bytes outstanding
  assign flush_start = ~flush_q & desc_valid_q & abort_req & ~last_hs;

  // Final byte dropped, or nothing left to drop
  assign flush_done = flush_q &
                      ((byte_rvalid_i & (count_q == DataLenW'(1))) |
                       (~byte_rvalid_i & data_empty_i) |
                       (count_q == '0));

  assign tx_end   = last_hs | flush_done;
  assign tx_end_o = tx_end;

  // Partial final word stays in the converter otherwise
  assign tx_queue_flush_o = tx_end & ((data_len_q % BytesPerWord) != '0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      desc_valid_q <= 1'b0;
    end else if (tx_end) begin
      desc_valid_q <= 1'b0;
    end else if (desc_rready_o) begin
      desc_valid_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (desc_rready_o) begin
      data_len_q <= desc_rdata_i.data_len;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pending_q <= 1'b0;
      flush_q   <= 1'b0;
      count_q   <= '0;
    end else begin
      if (start) begin
        pending_q <= 1'b1;
      end else if (tx_end) begin
        pending_q <= 1'b0;
      end

      if (flush_start) begin
        flush_q <= 1'b1;
      end else if (flush_done) begin
        flush_q <= 1'b0;
      end

      // Abort before the transfer began still has the full length to drop
      if (start || (flush_start && !pending_q)) begin
        count_q <= data_len_q;
      end else if (byte_rready_o) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- src/tti_tx_top.sv
// TTI transmit path top with APB slave, queues, word converter and descriptor handler
`timescale 1ns/10ps
`default_nettype none

module tti_tx_top (
  input  logic                  clk_i,
  input  logic                  rst_ni,

  input  tti_apb_pkg::apb_req_t apb_req_i,
  output tti_apb_pkg::apb_rsp_t apb_rsp_o,

  // Target FSM controls
  input  logic                  tx_start_i,
  input  logic                  tx_abort_i,
  input  logic                  recovery_mode_enter_i,
  output logic                  tx_desc_avail_o,

  // Byte stream
  output tti_tx_pkg::tx_byte_t  tx_byte_o,
  output logic                  tx_byte_valid_o,
  input  logic                  tx_byte_ready_i,
  output logic                  tx_end_o
);

  import tti_tx_pkg::*;

  logic              desc_wvalid;
  tx_desc_t          desc_wdata;
  logic              desc_full;
  logic              desc_rvalid;
  logic              desc_rready;
  tx_desc_t          desc_rdata;
  logic [DepthW-1:0] desc_depth;

  logic              data_wvalid;
  tx_word_t          data_wdata;
  logic              data_full;
  logic              data_rvalid;
  logic              data_rready;
  tx_word_t          data_rdata;
  logic [DepthW-1:0] data_depth;
  logic              data_empty;

  logic              byte_valid;
  logic              byte_ready;
  logic [ByteW-1:0]  byte_data;
  logic              tx_queue_flush;

  tti_apb_regs tti_apb_regs_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .apb_req_i     (apb_req_i),
    .apb_rsp_o     (apb_rsp_o),
    .desc_wvalid_o (desc_wvalid),
    .desc_wdata_o  (desc_wdata),
    .desc_full_i   (desc_full),
    .data_wvalid_o (data_wvalid),
    .data_wdata_o  (data_wdata),
    .data_full_i   (data_full),
    .desc_depth_i  (desc_depth),
    .data_depth_i  (data_depth)
  );

  tti_queue #(
    .payload_t (tx_desc_t),
    .Depth     (DescQueueDepth)
  ) desc_queue_inst (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .wvalid_i (desc_wvalid),
    .wdata_i  (desc_wdata),
    .full_o   (desc_full),
    .rvalid_o (desc_rvalid),
    .rready_i (desc_rready),
    .rdata_o  (desc_rdata),
    .depth_o  (desc_depth),
    .empty_o  ()
  );

  tti_queue #(
    .payload_t (tx_word_t),
    .Depth     (DataQueueDepth)
  ) data_queue_inst (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .wvalid_i (data_wvalid),
    .wdata_i  (data_wdata),
    .full_o   (data_full),
    .rvalid_o (data_rvalid),
    .rready_i (data_rready),
    .rdata_o  (data_rdata),
    .depth_o  (data_depth),
    .empty_o  (data_empty)
  );

  tx_word_to_byte tx_word_to_byte_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .word_rvalid_i (data_rvalid),
    .word_rready_o (data_rready),
    .word_rdata_i  (data_rdata),
    .byte_valid_o  (byte_valid),
    .byte_ready_i  (byte_ready),
    .byte_o        (byte_data),
    .flush_i       (tx_queue_flush)
  );

  descriptor_tx descriptor_tx_inst (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .desc_rvalid_i         (desc_rvalid),
    .desc_rready_o         (desc_rready),
    .desc_rdata_i          (desc_rdata),
    .byte_rvalid_i         (byte_valid),
    .byte_rready_o         (byte_ready),
    .byte_rdata_i          (byte_data),
    .data_depth_i          (data_depth),
    .data_empty_i          (data_empty),
    .tx_queue_flush_o      (tx_queue_flush),
    .tx_start_i            (tx_start_i),
    .tx_abort_i            (tx_abort_i),
    .recovery_mode_enter_i (recovery_mode_enter_i),
    .tx_desc_avail_o       (tx_desc_avail_o),
    .tx_byte_o             (tx_byte_o),
    .tx_byte_valid_o       (tx_byte_valid_o),
    .tx_byte_ready_i       (tx_byte_ready_i),
    .tx_end_o              (tx_end_o)
  );

endmodule

`default_nettype wire

//--- test/tb_tti_tx.sv
// Directed testbench for the TTI transmit path, from APB writes to the byte stream
`timescale 1ns/10ps
`default_nettype none

module tb_tti_tx;

  import tti_apb_pkg::*;
  import tti_tx_pkg::*;

  // Rough cycle budget of all tests, with a wide margin on top
  localparam int unsigned SuiteCycles   = 2000;
  localparam int unsigned TimeoutCycles = 10 * SuiteCycles;

  logic        clk_i;
  logic        rst_ni;
  apb_req_t    apb_req;
  apb_rsp_t    apb_rsp;
  logic        tx_start;
  logic        tx_abort;
  logic        recovery_mode_enter;
  logic        tx_desc_avail;
  tx_byte_t    tx_byte;
  logic        tx_byte_valid;
  logic        tx_byte_ready;
  logic        tx_end;

  integer      seed = 32'h4b1f_bf93;
  int unsigned cycle_count = 0;

  // Bytes the target FSM should see, lowest byte of each word first
  logic [ByteW-1:0] exp_bytes[$];

  tti_tx_top tti_tx_top_inst (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .apb_req_i             (apb_req),
    .apb_rsp_o             (apb_rsp),
    .tx_start_i            (tx_start),
    .tx_abort_i            (tx_abort),
    .recovery_mode_enter_i (recovery_mode_enter),
    .tx_desc_avail_o       (tx_desc_avail),
    .tx_byte_o             (tx_byte),
    .tx_byte_valid_o       (tx_byte_valid),
    .tx_byte_ready_i       (tx_byte_ready),
    .tx_end_o              (tx_end)
  );

  initial begin
    clk_i = 1'b0;
    forever begin
      #5 clk_i = ~clk_i;
    end
  end

  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TimeoutCycles) begin
      $display("Timeout: the tests did not finish within %0d cycles", TimeoutCycles);
      $display("TESTS FAILED");
      $fatal(1, "Simulation timed out");
    end
  end

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("ERROR at %0t: %s, got 0x%0h, expected 0x%0h", $time, what, actual, expected);
      $display("TESTS FAILED");
      $fatal(1, "Check failed");
    end
  endtask

  task automatic apb_access(input logic write, input logic [ApbAddrW-1:0] addr,
                            input logic [ApbDataW-1:0] wdata,
                            output logic [ApbDataW-1:0] rdata, output logic err);
    @(negedge clk_i);
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = write;
    apb_req.paddr   = addr;
    apb_req.pwdata  = wdata;
    @(negedge clk_i);
    apb_req.penable = 1'b1;
    #1;
    check_value(32'(apb_rsp.pready), 32'd1, "pready in access phase");
    rdata = apb_rsp.prdata;
    err   = apb_rsp.pslverr;
    @(negedge clk_i);
    apb_req.psel    = 1'b0;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = 1'b0;
  endtask

  task automatic push_descriptor(input logic [DataLenW-1:0] len);
    tx_desc_t            desc;
    logic [ApbDataW-1:0] rdata;
    logic                err;
    desc          = '0;
    desc.data_len = len;
    apb_access(1'b1, TX_DESC_ADDR, 32'(desc), rdata, err);
    check_value(32'(err), 32'd0, "pslverr on descriptor write");
  endtask

  // Only the first used_bytes of the word belong to a descriptor
  task automatic push_word(input tx_word_t word, input int unsigned used_bytes);
    logic [ApbDataW-1:0] rdata;
    logic                err;
    apb_access(1'b1, TX_DATA_ADDR, word, rdata, err);
    check_value(32'(err), 32'd0, "pslverr on data write");
    for (int unsigned i = 0; i < used_bytes; i++) begin
      exp_bytes.push_back(word[i*ByteW +: ByteW]);
    end
  endtask

  task automatic pulse_start();
    @(negedge clk_i);
    tx_start = 1'b1;
    #1;
    check_value(32'(tx_desc_avail), 32'd1, "descriptor available at start");
    @(negedge clk_i);
    tx_start = 1'b0;
  endtask

  // Accepts count bytes; a complete transfer ends with last and one end pulse
  task automatic collect_bytes(input int unsigned count, input bit complete,
                               input bit random_ready);
    int unsigned      got;
    bit               stalled;
    bit               hs;
    tx_byte_t         held;
    integer           rnd;
    logic [ByteW-1:0] exp_byte;
    logic             exp_last;
    got     = 0;
    stalled = 1'b0;
    held    = '0;
    while (got < count) begin
      @(negedge clk_i);
      if (random_ready) begin
        rnd           = $random(seed);
        tx_byte_ready = rnd[1:0] != 2'b00;
      end else begin
        tx_byte_ready = 1'b1;
      end
      #1;
      // Byte refused last cycle must still be there unchanged
      if (stalled) begin
        check_value(32'(tx_byte_valid), 32'd1, "valid held while stalled");
        check_value(32'(tx_byte), 32'(held), "byte held while stalled");
      end
      hs       = tx_byte_valid & tx_byte_ready;
      exp_last = complete && (got == count - 1);
      check_value(32'(tx_end), 32'(hs & exp_last), "end pulse with the last byte");
      if (hs) begin
        check_value(32'(exp_bytes.size() != 0), 32'd1, "byte beyond the written data");
        exp_byte = exp_bytes.pop_front();
        check_value(32'(tx_byte.data), 32'(exp_byte), $sformatf("data of byte %0d", got));
        check_value(32'(tx_byte.last), 32'(exp_last), $sformatf("last of byte %0d", got));
        got++;
      end
      stalled = tx_byte_valid & ~tx_byte_ready;
      held    = tx_byte;
    end
    if (complete) begin
      @(negedge clk_i);
      tx_byte_ready = 1'b0;
      repeat (4) begin
        #1;
        check_value(32'(tx_byte_valid), 32'd0, "no byte after the last one");
        check_value(32'(tx_end), 32'd0, "no second end pulse");
        @(negedge clk_i);
      end
      check_value(exp_bytes.size(), 32'd0, "bytes left over after the transfer");
    end
  endtask

  task automatic idle_without_descriptor();
    $display("Running: start without a descriptor");
    check_value(32'(tx_byte_valid), 32'd0, "valid after reset");
    check_value(32'(tx_end), 32'd0, "end after reset");
    check_value(32'(apb_rsp.pslverr), 32'd0, "pslverr after reset");
    @(negedge clk_i);
    tx_start      = 1'b1;
    tx_byte_ready = 1'b1;
    repeat (20) begin
      #1;
      check_value(32'(tx_desc_avail), 32'd0, "descriptor available on empty queue");
      check_value(32'(tx_byte_valid), 32'd0, "byte without a descriptor");
      @(negedge clk_i);
    end
    tx_start      = 1'b0;
    tx_byte_ready = 1'b0;
  endtask

  task automatic basic_transfer();
    $display("Running: basic transfer");
    push_descriptor(16'd8);
    push_word(32'h4433_2211, 4);
    push_word(32'h8877_6655, 4);
    pulse_start();
    collect_bytes(8, 1'b1, 1'b0);
  endtask

  // Second transfer must start at C0, not at the leftover B1
  task automatic partial_last_word();
    $display("Running: partial last word");
    push_descriptor(16'd5);
    push_descriptor(16'd4);
    push_word(32'hA3A2_A1A0, 4);
    push_word(32'hB3B2_B1B0, 1);
    pulse_start();
    collect_bytes(5, 1'b1, 1'b0);
    push_word(32'hC3C2_C1C0, 4);
    pulse_start();
    collect_bytes(4, 1'b1, 1'b0);
  endtask

  task automatic back_pressure();
    $display("Running: back-pressure");
    push_descriptor(16'd12);
    push_word(32'h1312_1110, 4);
    push_word(32'h2322_2120, 4);
    push_word(32'h3332_3130, 4);
    pulse_start();
    collect_bytes(12, 1'b1, 1'b1);
  endtask

  task automatic abort_transfer();
    bit flushed;
    $display("Running: abort");
    push_descriptor(16'd8);
    push_descriptor(16'd4);
    push_word(32'h5453_5251, 2);
    push_word(32'h6463_6261, 0);
    push_word(32'h7473_7271, 4);
    pulse_start();
    collect_bytes(2, 1'b0, 1'b0);
    @(negedge clk_i);
    tx_abort      = 1'b1;
    tx_byte_ready = 1'b0;
    @(negedge clk_i);
    tx_abort = 1'b0;
    flushed  = 1'b0;
    // Remaining six bytes are dropped inside the DUT
    while (!flushed) begin
      #1;
      check_value(32'(tx_byte_valid), 32'd0, "byte shown during flush");
      flushed = tx_end;
      @(negedge clk_i);
    end
    pulse_start();
    collect_bytes(4, 1'b1, 1'b0);
  endtask

  task automatic status_and_errors();
    localparam int unsigned WordsPushed = 4;
    logic [ApbDataW-1:0] rdata;
    logic [ApbDataW-1:0] exp_status;
    logic                err;
    $display("Running: APB status and errors");
    for (int unsigned i = 0; i < WordsPushed; i++) begin
      push_word(32'hF0F0_0000 | 32'(i), 0);
    end
    for (int unsigned i = 0; i < DescQueueDepth; i++) begin
      push_descriptor(16'd4);
    end
    // Converter takes the first word, so the queue reports one less
    exp_status = {16'(DescQueueDepth), 16'(WordsPushed - 1)};
    apb_access(1'b0, STATUS_ADDR, '0, rdata, err);
    check_value(32'(err), 32'd0, "pslverr on status read");
    check_value(rdata, exp_status, "queue depths in status");
    apb_access(1'b1, TX_DESC_ADDR, 32'd4, rdata, err);
    check_value(32'(err), 32'd1, "pslverr on full descriptor queue");
    apb_access(1'b1, 12'h010, 32'hDEAD_BEEF, rdata, err);
    check_value(32'(err), 32'd1, "pslverr on unmapped write");
    apb_access(1'b0, 12'h00C, '0, rdata, err);
    check_value(32'(err), 32'd1, "pslverr on unmapped read");
    apb_access(1'b0, STATUS_ADDR, '0, rdata, err);
    check_value(rdata, exp_status, "depths after refused writes");
  endtask

  initial begin
    rst_ni              = 1'b0;
    apb_req             = '0;
    tx_start            = 1'b0;
    tx_abort            = 1'b0;
    recovery_mode_enter = 1'b0;
    tx_byte_ready       = 1'b0;
    repeat (10) @(negedge clk_i);
    rst_ni = 1'b1;
    #1;
    idle_without_descriptor();
    basic_transfer();
    partial_last_word();
    back_pressure();
    abort_transfer();
    status_and_errors();
    @(negedge clk_i);
    $display("TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- compile.f
src/tti_apb_pkg.sv
src/tti_tx_pkg.sv
src/tti_apb_regs.sv
src/tti_queue.sv
src/tx_word_to_byte.sv
src/descriptor_tx.sv
src/tti_tx_top.sv
test/tb_tti_tx.sv

//--- Makefile
# Verilator build and run of the TTI transmit path testbench

VERILATOR ?= verilator
TOP       ?= tb_tti_tx
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: compile
	$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^TESTS PASSED$$" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
